// File: tsn_nic.f
+incdir+common
common/tsn_pkg.sv
hw/slot_timer.sv
hw/frame_rx.sv
tx_gate/tx_gate.sv
hw/tsn_nic.sv
tests/tb_clock.sv
tests/tsn_checker.sv
tests/tsn_nic_tb.sv

// File: Makefile
TOP := tsn_nic_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f tsn_nic.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only -Wall --timing -f tsn_nic.f --top-module tsn_nic

clean:
	rm -rf obj_dir

// File: tests/tsn_nic_trace.txt
# config line: slot_length period(slots-1) gate_mask_p0(hex) gate_mask_p1(hex)
# frame lines: ingress_port start_edge byte_count first_byte(hex) errored_byte(-1 for none)
8 3 0005 0003
# both directions at once, p0 to p1 open, p1 to p0 closed
0 40 6 10 -1
1 40 6 80 -1
# closed slot with an errored byte
0 50 10 20 3
# open slot, error from byte 2
1 64 5 a0 2
# crosses two slot boundaries, decision holds
0 70 12 30 -1
# dropped, runs into an open slot
1 78 9 fe -1
# both open, data wraps, error on the first byte
0 100 4 ff 0
1 100 4 40 -1
# error on the last byte
1 117 8 50 7
0 130 3 60 -1
# one dropped, one forwarded in the same slot
0 150 20 70 10
1 150 2 90 1
# single-byte frame in a closed slot
0 180 1 01 -1
1 190 16 c0 -1
0 200 7 d0 4

// File: tests/tsn_nic_tb.sv
// run from the project root, the trace path is relative to it; inputs change on falling edges
`timescale 1ns/1ps

module tsn_nic_tb import tsn_pkg::*; ();

  logic       clk;
  logic       rst_n;
  slot_len_t  slot_length;
  slot_idx_t  sched_period;
  gate_mask_t gate_mask [2];
  logic       rx_dv [2];
  gmii_byte_t rx_d [2];
  logic       rx_er [2];
  logic       tx_en [2];
  gmii_byte_t tx_d [2];
  logic       tx_er [2];
  logic       cycle_start;
  stat_cnt_t  rx_cnt [2];
  stat_cnt_t  drop_cnt [2];
  int         err_cnt;
  int         chk_cnt;

  // frame list from the trace
  int fr_port [$];
  int fr_start [$];
  int fr_len [$];
  int fr_first [$];
  int fr_err [$];
  int cyc_len;
  int last_end;
  bit trace_ok;

  tb_clock clock_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  tsn_nic tsn_nic_inst (
    .i_clk (clk), .i_rst_n (rst_n),
    .i_time_slot_length (slot_length), .i_schedule_period (sched_period),
    .i_gate_mask_p0 (gate_mask[0]), .i_gate_mask_p1 (gate_mask[1]),
    .i_gmii_dv_p0 (rx_dv[0]), .iv_gmii_rxd_p0 (rx_d[0]), .i_gmii_er_p0 (rx_er[0]),
    .i_gmii_dv_p1 (rx_dv[1]), .iv_gmii_rxd_p1 (rx_d[1]), .i_gmii_er_p1 (rx_er[1]),
    .o_gmii_tx_en_p0 (tx_en[0]), .ov_gmii_txd_p0 (tx_d[0]), .o_gmii_tx_er_p0 (tx_er[0]),
    .o_gmii_tx_en_p1 (tx_en[1]), .ov_gmii_txd_p1 (tx_d[1]), .o_gmii_tx_er_p1 (tx_er[1]),
    .o_cycle_start (cycle_start),
    .ov_rx_frame_cnt_p0 (rx_cnt[0]), .ov_rx_frame_cnt_p1 (rx_cnt[1]),
    .ov_drop_cnt_p0 (drop_cnt[0]), .ov_drop_cnt_p1 (drop_cnt[1])
  );

  tsn_checker tsn_checker_inst (
    .i_clk (clk), .i_rst_n (rst_n),
    .i_tx_en_p0 (tx_en[0]), .i_txd_p0 (tx_d[0]), .i_tx_er_p0 (tx_er[0]),
    .i_tx_en_p1 (tx_en[1]), .i_txd_p1 (tx_d[1]), .i_tx_er_p1 (tx_er[1]),
    .i_cycle_start (cycle_start),
    .i_rx_cnt_p0 (rx_cnt[0]), .i_rx_cnt_p1 (rx_cnt[1]),
    .i_drop_cnt_p0 (drop_cnt[0]), .i_drop_cnt_p1 (drop_cnt[1]),
    .o_err_cnt (err_cnt), .o_chk_cnt (chk_cnt)
  );

  task automatic read_trace();
    int    fd;
    int    port;
    int    start;
    int    len;
    int    first;
    int    err;
    string line;
    fd = $fopen("tests/tsn_nic_trace.txt", "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) < 2 || line[0] == "#") begin
        continue;
      end
      if (!trace_ok) begin
        trace_ok = ($sscanf(line, "%d %d %h %h", slot_length, sched_period,
                            gate_mask[0], gate_mask[1]) == 4);
      end else if ($sscanf(line, "%d %d %d %h %d", port, start, len, first, err) == 5) begin
        fr_port.push_back(port);
        fr_start.push_back(start);
        fr_len.push_back(len);
        fr_first.push_back(first);
        fr_err.push_back(err);
        if (start + len > last_end) begin
          last_end = start + len;
        end
      end
    end
    $fclose(fd);
    cyc_len = int'(slot_length) * (int'(sched_period) + 1);
  endtask

  // byte k of a frame carries first byte plus k, er only on the marked byte
  task automatic drive_lanes(input int e);
    int k;
    for (int p = 0; p < 2; p++) begin
      rx_dv[p] = 1'b0;
      rx_d[p]  = '0;
      rx_er[p] = 1'b0;
      foreach (fr_port[f]) begin
        k = e - fr_start[f];
        if (fr_port[f] == p && k >= 0 && k < fr_len[f]) begin
          rx_dv[p] = 1'b1;
          rx_d[p]  = gmii_byte_t'(fr_first[f] + k);
          rx_er[p] = (k == fr_err[f]);
        end
      end
    end
  endtask

  initial begin
    slot_length  = '0;
    sched_period = '0;
    for (int p = 0; p < 2; p++) begin
      gate_mask[p] = '0;
      rx_dv[p]     = 1'b0;
      rx_d[p]      = '0;
      rx_er[p]     = 1'b0;
    end
    read_trace();
    if (!trace_ok) begin
      $display("could not read a configuration line from tests/tsn_nic_trace.txt");
      $display("Errors found");
    end else begin
      wait (rst_n);
      for (int e = 0; e < last_end + cyc_len + 8; e++) begin
        drive_lanes(e);
        @(posedge clk);
        @(negedge clk);
      end
      @(posedge clk);
      $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0 && chk_cnt > 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
    end
    $finish;
  end

  ////////////////////
  // watchdog
  ////////////////////
  initial begin
    wait (rst_n);
    // last frame end, two schedule cycles and 100 spare cycles
    #((last_end + 2 * cyc_len + 100) * 20);
    $display("timeout: the run did not end within the time set by the trace");
    $display("Errors found");
    $finish;
  end

endmodule

// File: tests/tsn_checker.sv
// predicts every DUT output from the trace; samples on falling edges, edge -1 is the reset state
`timescale 1ns/1ps

module tsn_checker import tsn_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_tx_en_p0,
  input  gmii_byte_t i_txd_p0,
  input  logic       i_tx_er_p0,
  input  logic       i_tx_en_p1,
  input  gmii_byte_t i_txd_p1,
  input  logic       i_tx_er_p1,
  input  logic       i_cycle_start,
  input  stat_cnt_t  i_rx_cnt_p0,
  input  stat_cnt_t  i_rx_cnt_p1,
  input  stat_cnt_t  i_drop_cnt_p0,
  input  stat_cnt_t  i_drop_cnt_p1,
  output int         o_err_cnt,
  output int         o_chk_cnt
);

  int slot_len;
  int period;
  int mask [2];
  bit cfg_ok;
  int edge_idx;
  int fr_port [$];
  int fr_start [$];
  int fr_len [$];
  int fr_first [$];
  int fr_err [$];

  task automatic read_trace();
    int    fd;
    int    port;
    int    start;
    int    len;
    int    first;
    int    err;
    string line;
    fd = $fopen("tests/tsn_nic_trace.txt", "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) < 2 || line[0] == "#") begin
        continue;
      end
      if (!cfg_ok) begin
        cfg_ok = ($sscanf(line, "%d %d %h %h", slot_len, period, mask[0], mask[1]) == 4)
                 && slot_len > 0;
      end else if ($sscanf(line, "%d %d %d %h %d", port, start, len, first, err) == 5) begin
        fr_port.push_back(port);
        fr_start.push_back(start);
        fr_len.push_back(len);
        fr_first.push_back(first);
        fr_err.push_back(err);
      end
    end
    $fclose(fd);
  endtask

  // egress mask bit at the slot in force one edge after the first byte
  function automatic bit gate_open(int f);
    int slot;
    slot = (fr_start[f] + 1) / slot_len % (period + 1);
    return mask[1 - fr_port[f]][slot];
  endfunction

  function automatic int count_frames(int p, int last_start, bit closed_only);
    int n;
    n = 0;
    foreach (fr_port[f]) begin
      if (fr_port[f] == p && fr_start[f] <= last_start && !(closed_only && gate_open(f))) begin
        n++;
      end
    end
    return n;
  endfunction

  // byte k leaves on the other port one edge after the receiver registers it
  task automatic predict_tx(input int q, input int e, output int en, output int data,
                            output int er);
    int k;
    en   = 0;
    data = 0;
    er   = 0;
    foreach (fr_port[f]) begin
      k = e - 1 - fr_start[f];
      if (fr_port[f] == 1 - q && k >= 0 && k < fr_len[f] && gate_open(f)) begin
        en   = 1;
        data = (fr_first[f] + k) % 256;
        er   = (fr_err[f] >= 0 && k >= fr_err[f]) ? 1 : 0;
      end
    end
  endtask

  task automatic check_value(input string sig, input int e, input int expected,
                             input int actual);
    o_chk_cnt++;
    if (expected != actual) begin
      o_err_cnt++;
      $display("** Error %s (edge %0d): expected 0x%0h, actual 0x%0h", sig, e, expected, actual);
    end
  endtask

  task automatic check_edge(input int e);
    int en;
    int data;
    int er;
    int pulse;
    pulse = (e >= 0 && (e + 1) % (slot_len * (period + 1)) == 0) ? 1 : 0;
    check_value("cycle_start", e, pulse, int'(i_cycle_start));
    predict_tx(0, e, en, data, er);
    check_value("tx_en_p0", e, en, int'(i_tx_en_p0));
    check_value("txd_p0", e, data, int'(i_txd_p0));
    check_value("tx_er_p0", e, er, int'(i_tx_er_p0));
    predict_tx(1, e, en, data, er);
    check_value("tx_en_p1", e, en, int'(i_tx_en_p1));
    check_value("txd_p1", e, data, int'(i_txd_p1));
    check_value("tx_er_p1", e, er, int'(i_tx_er_p1));
    check_value("rx_frame_cnt_p0", e, count_frames(0, e, 1'b0), int'(i_rx_cnt_p0));
    check_value("rx_frame_cnt_p1", e, count_frames(1, e, 1'b0), int'(i_rx_cnt_p1));
    // drops land one edge after start of frame
    check_value("drop_cnt_p0", e, count_frames(1, e - 1, 1'b1), int'(i_drop_cnt_p0));
    check_value("drop_cnt_p1", e, count_frames(0, e - 1, 1'b1), int'(i_drop_cnt_p1));
  endtask

  initial begin
    o_err_cnt = 0;
    o_chk_cnt = 0;
    read_trace();
    if (!cfg_ok) begin
      $display("checker could not read a configuration line from the trace file");
      o_err_cnt++;
    end else begin
      wait (i_rst_n);
      check_edge(-1);
      edge_idx = 0;
      forever begin
        @(posedge i_clk);
        @(negedge i_clk);
        check_edge(edge_idx);
        edge_idx++;
      end
    end
  end

endmodule

// File: tests/tb_clock.sv
// 20 ns clock; reset is held for 10 rising edges and released on a falling edge
`timescale 1ns/1ps

module tb_clock (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #10 o_clk = ~o_clk;
    end
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (10) @(posedge o_clk);
    // edge 0 is the next rising edge
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

// File: hw/tsn_nic.sv
// both GMII ports run on i_clk at 125 MHz; configuration inputs must be static out of reset
`timescale 1ns/1ps

module tsn_nic import tsn_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,

  input  slot_len_t  i_time_slot_length,
  input  slot_idx_t  i_schedule_period,
  input  gate_mask_t i_gate_mask_p0,
  input  gate_mask_t i_gate_mask_p1,

  input  logic       i_gmii_dv_p0,
  input  gmii_byte_t iv_gmii_rxd_p0,
  input  logic       i_gmii_er_p0,

  input  logic       i_gmii_dv_p1,
  input  gmii_byte_t iv_gmii_rxd_p1,
  input  logic       i_gmii_er_p1,

  output logic       o_gmii_tx_en_p0,
  output gmii_byte_t ov_gmii_txd_p0,
  output logic       o_gmii_tx_er_p0,

  output logic       o_gmii_tx_en_p1,
  output gmii_byte_t ov_gmii_txd_p1,
  output logic       o_gmii_tx_er_p1,

  output logic       o_cycle_start,

  output stat_cnt_t  ov_rx_frame_cnt_p0,
  output stat_cnt_t  ov_rx_frame_cnt_p1,
  output stat_cnt_t  ov_drop_cnt_p0,
  output stat_cnt_t  ov_drop_cnt_p1
);

  slot_idx_t  wv_slot;

  logic       w_dv_p0;
  gmii_byte_t wv_data_p0;
  logic       w_er_p0;
  logic       w_sof_p0;

  logic       w_dv_p1;
  gmii_byte_t wv_data_p1;
  logic       w_er_p1;
  logic       w_sof_p1;

  slot_timer slot_timer_inst (
    .i_clk              (i_clk),
    .i_rst_n            (i_rst_n),
    .i_time_slot_length (i_time_slot_length),
    .i_schedule_period  (i_schedule_period),
    .o_slot             (wv_slot),
    .o_cycle_start      (o_cycle_start)
  );

  ////////////////////
  // receivers
  ////////////////////
  frame_rx rx_p0 (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_gmii_dv   (i_gmii_dv_p0),
    .i_gmii_rxd  (iv_gmii_rxd_p0),
    .i_gmii_er   (i_gmii_er_p0),
    .o_dv        (w_dv_p0),
    .o_data      (wv_data_p0),
    .o_er        (w_er_p0),
    .o_sof       (w_sof_p0),
    .o_frame_cnt (ov_rx_frame_cnt_p0)
  );

  frame_rx rx_p1 (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_gmii_dv   (i_gmii_dv_p1),
    .i_gmii_rxd  (iv_gmii_rxd_p1),
    .i_gmii_er   (i_gmii_er_p1),
    .o_dv        (w_dv_p1),
    .o_data      (wv_data_p1),
    .o_er        (w_er_p1),
    .o_sof       (w_sof_p1),
    .o_frame_cnt (ov_rx_frame_cnt_p1)
  );

  // cross-connects the two ports
  tx_gate tx_gate_inst (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_slot          (wv_slot),
    .i_gate_mask_p0  (i_gate_mask_p0),
    .i_gate_mask_p1  (i_gate_mask_p1),
    .i_dv_p0         (w_dv_p0),
    .i_data_p0       (wv_data_p0),
    .i_er_p0         (w_er_p0),
    .i_sof_p0        (w_sof_p0),
    .i_dv_p1         (w_dv_p1),
    .i_data_p1       (wv_data_p1),
    .i_er_p1         (w_er_p1),
    .i_sof_p1        (w_sof_p1),
    .o_gmii_tx_en_p0 (o_gmii_tx_en_p0),
    .o_gmii_txd_p0   (ov_gmii_txd_p0),
    .o_gmii_tx_er_p0 (o_gmii_tx_er_p0),
    .o_gmii_tx_en_p1 (o_gmii_tx_en_p1),
    .o_gmii_txd_p1   (ov_gmii_txd_p1),
    .o_gmii_tx_er_p1 (o_gmii_tx_er_p1),
    .o_drop_cnt_p0   (ov_drop_cnt_p0),
    .o_drop_cnt_p1   (ov_drop_cnt_p1)
  );

endmodule

// File: tx_gate/tx_gate.sv
// p0 traffic leaves on p1 and p1 traffic on p0; masks must be static, refused frames are lost
`timescale 1ns/1ps

module tx_gate import tsn_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,

  input  slot_idx_t  i_slot,
  input  gate_mask_t i_gate_mask_p0,
  input  gate_mask_t i_gate_mask_p1,

  input  logic       i_dv_p0,
  input  gmii_byte_t i_data_p0,
  input  logic       i_er_p0,
  input  logic       i_sof_p0,

  input  logic       i_dv_p1,
  input  gmii_byte_t i_data_p1,
  input  logic       i_er_p1,
  input  logic       i_sof_p1,

  output logic       o_gmii_tx_en_p0,
  output gmii_byte_t o_gmii_txd_p0,
  output logic       o_gmii_tx_er_p0,

  output logic       o_gmii_tx_en_p1,
  output gmii_byte_t o_gmii_txd_p1,
  output logic       o_gmii_tx_er_p1,

  output stat_cnt_t  o_drop_cnt_p0,
  output stat_cnt_t  o_drop_cnt_p1
);

  // indexed by egress port
  logic [1:0] in_dv;
  logic [1:0] in_er;
  logic [1:0] in_sof;
  gmii_byte_t in_data [2];
  gate_mask_t in_mask [2];

  // egress p0 is fed from p1, egress p1 from p0
  assign in_dv      = {i_dv_p0, i_dv_p1};
  assign in_er      = {i_er_p0, i_er_p1};
  assign in_sof     = {i_sof_p0, i_sof_p1};
  assign in_data[0] = i_data_p1;
  assign in_data[1] = i_data_p0;
  assign in_mask[0] = i_gate_mask_p0;
  assign in_mask[1] = i_gate_mask_p1;

  for (genvar e = 0; e < 2; e++) begin : g_egress
    logic       pass_q;
    logic       pass;
    logic       fwd;
    logic       tx_en_q;
    logic       tx_er_q;
    gmii_byte_t txd_q;
    stat_cnt_t  drop_q;

    // decision taken once, at start of frame
    assign pass = in_sof[e] ? in_mask[e][i_slot] : pass_q;
    assign fwd  = in_dv[e] & pass;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        pass_q <= 1'b0;
      end else if (in_sof[e]) begin
        pass_q <= in_mask[e][i_slot];
      end else if (!in_dv[e]) begin
        pass_q <= 1'b0;
      end
    end

    ////////////////////
    // tx lane
    ////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        tx_en_q <= 1'b0;
        tx_er_q <= 1'b0;
        txd_q   <= '0;
      end else begin
        tx_en_q <= fwd;
        tx_er_q <= fwd & in_er[e];
        txd_q   <= fwd ? in_data[e] : '0;
      end
    end

    // refused frames counted on the egress side
    always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        drop_q <= '0;
      end else if (in_sof[e] && !in_mask[e][i_slot]) begin
        drop_q <= drop_q + stat_cnt_t'(1);
      end
    end
  end

  assign o_gmii_tx_en_p0 = g_egress[0].tx_en_q;
  assign o_gmii_txd_p0   = g_egress[0].txd_q;
  assign o_gmii_tx_er_p0 = g_egress[0].tx_er_q;
  assign o_drop_cnt_p0   = g_egress[0].drop_q;

  assign o_gmii_tx_en_p1 = g_egress[1].tx_en_q;
  assign o_gmii_txd_p1   = g_egress[1].txd_q;
  assign o_gmii_tx_er_p1 = g_egress[1].tx_er_q;
  assign o_drop_cnt_p1   = g_egress[1].drop_q;

endmodule

// File: hw/frame_rx.sv
// frames need at least one idle cycle between them; back-to-back dv merges two frames into one
`timescale 1ns/1ps

module frame_rx import tsn_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,

  input  logic       i_gmii_dv,
  input  gmii_byte_t i_gmii_rxd,
  input  logic       i_gmii_er,

  output logic       o_dv,
  output gmii_byte_t o_data,
  output logic       o_er,
  output logic       o_sof,

  output stat_cnt_t  o_frame_cnt
);

  logic frame_start;

  // rising edge of dv against the previous sample in o_dv
  assign frame_start = i_gmii_dv & ~o_dv;

  ////////////////////
  // lane register
  ////////////////////
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_dv  <= 1'b0;
      o_sof <= 1'b0;
    end else begin
      o_dv  <= i_gmii_dv;
      o_sof <= frame_start;
    end
  end

  always_ff @(posedge i_clk) begin
    o_data <= i_gmii_rxd;
  end

  // error sticks until dv falls
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_er <= 1'b0;
    end else if (!i_gmii_dv) begin
      o_er <= 1'b0;
    end else begin
      o_er <= o_er | i_gmii_er;
    end
  end

  ////////////////////
  // frame counter
  ////////////////////
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_frame_cnt <= '0;
    end else if (frame_start) begin
      o_frame_cnt <= o_frame_cnt + stat_cnt_t'(1);
    end
  end

endmodule

// File: hw/slot_timer.sv
// length and period must be static out of reset; a length of zero is not supported
`timescale 1ns/1ps

module slot_timer import tsn_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,

  input  slot_len_t i_time_slot_length,
  input  slot_idx_t i_schedule_period,

  output slot_idx_t o_slot,
  output logic      o_cycle_start
);

  slot_len_t tick_cnt;
  slot_len_t len_m1;
  logic      slot_end;
  logic      cycle_end;

  assign len_m1    = i_time_slot_length - slot_len_t'(1);
  assign slot_end  = (tick_cnt == len_m1);
  assign cycle_end = slot_end && (o_slot == i_schedule_period);

  ////////////////////
  // tick counter
  ////////////////////
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      tick_cnt <= '0;
    end else if (slot_end) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + slot_len_t'(1);
    end
  end

  ////////////////////
  // slot counter
  ////////////////////
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_slot <= '0;
    end else if (cycle_end) begin
      o_slot <= '0;
    end else if (slot_end) begin
      o_slot <= o_slot + slot_idx_t'(1);
    end
  end

  // one pulse after the edge where the slot wraps to 0
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_cycle_start <= 1'b0;
    end else begin
      o_cycle_start <= cycle_end;
    end
  end

endmodule

// File: common/tsn_pkg.sv
// shared types for the two-port TSN end point; widths come from tsn_macros.svh
`include "tsn_macros.svh"

package tsn_pkg;

  // one GMII lane byte
  typedef logic [7:0] gmii_byte_t;

  // clocks per slot, zero is not a legal length
  typedef logic [`TSN_SLOT_LEN_W-1:0] slot_len_t;

  // slot number, also the period stored as slots minus one
  typedef logic [`TSN_SLOT_IDX_W-1:0] slot_idx_t;

  // one open bit per slot
  typedef logic [`TSN_NUM_SLOTS-1:0] gate_mask_t;

  // wrapping frame counter
  typedef logic [`TSN_CNT_W-1:0] stat_cnt_t;

endpackage

// File: common/tsn_macros.svh
// widths and sizes are fixed at compile time; the slot count must stay 2**TSN_SLOT_IDX_W
`ifndef TSN_MACROS_SVH
`define TSN_MACROS_SVH

// clocks per slot, 1 to 2047
`define TSN_SLOT_LEN_W 11

// slot index and schedule period
`define TSN_SLOT_IDX_W 4
`define TSN_NUM_SLOTS  16

// statistics counters wrap
`define TSN_CNT_W      16

`endif
